// ==== project.f ====
+incdir+test
source/rv_isa_pkg.sv
source/decode_pkg.sv
source/insn_decoder.sv
source/rob_id_allocator.sv
source/decode_ctrl_regs.sv
source/decode_stage.sv
test/decode_tb.sv

// ==== source/decode_ctrl_regs.sv ====
// decode configuration registers: custom extension enables and an illegal instruction counter
module decode_ctrl_regs #(
  parameter int CNT_W = 8
) (
  input  logic        clk,
  input  logic        rst_i,
  input  logic        cfg_we_i,
  input  logic [1:0]  cfg_addr_i,
  input  logic [31:0] cfg_wdata_i,
  output logic [31:0] cfg_rdata_o,
  input  logic        illegal_i,
  output logic        ext_lbcmp_en_o,
  output logic        ext_alu_en_o
);

  // bit 0 lbcmp, bit 1 alu extension
  logic [1:0]       en_q;
  logic [CNT_W-1:0] cnt_q;

  always_ff @(posedge clk) begin
    if (rst_i) begin
      en_q  <= 2'b11;
      cnt_q <= '0;
    end else begin
      if (cfg_we_i && cfg_addr_i == 2'd0) begin
        en_q <= cfg_wdata_i[1:0];
      end
      // any write clears, otherwise count and saturate
      if (cfg_we_i && cfg_addr_i == 2'd1) begin
        cnt_q <= '0;
      end else if (illegal_i && cnt_q != '1) begin
        cnt_q <= cnt_q + 1'b1;
      end
    end
  end

  always_comb begin
    case (cfg_addr_i)
      2'd0:    cfg_rdata_o = {30'd0, en_q};
      2'd1:    cfg_rdata_o = 32'(cnt_q);
      default: cfg_rdata_o = '0;
    endcase
  end

  assign ext_lbcmp_en_o = en_q[0];
  assign ext_alu_en_o   = en_q[1];

endmodule

// ==== source/decode_pkg.sv ====
// pipeline packets exchanged by the decode stage with fetch, the reorder buffer and rename
package decode_pkg;

  // widest reorder-buffer id, actual depth comes from ROB_DEPTH
  localparam int ROB_ID_W = 7;

  typedef struct packed {
    logic              error;
    logic [31:1]       addr;
    rv_isa_pkg::insn_u insn;
    logic [15:0]       bptag;
    logic              bptaken;
  } fetch_pkt_t;

  // retop is {branch, csr, jalr, store, funct3}
  typedef struct packed {
    logic                error;
    rv_isa_pkg::ecause_e ecause;
    logic [6:0]          retop;
    logic [5:0]          rd;
    logic [31:2]         addr;
    logic                forward;
    logic [31:2]         target;
    logic [15:0]         bptag;
    logic                bptaken;
  } rob_entry_t;

  typedef struct packed {
    logic [4:0]          rsop;
    logic [ROB_ID_W-1:0] robid;
    logic                uses_rs1;
    logic                uses_rs2;
    logic                uses_imm;
    logic                uses_memory;
    logic                uses_pc;
    logic                csr_access;
    logic                inhibit;
    logic [4:0]          rs1;
    logic [4:0]          rs2;
    logic [5:0]          rd;
    logic [31:0]         imm;
  } rename_uop_t;

endpackage

// ==== source/decode_stage.sv ====
// decode stage top level: decoder, reorder-buffer id allocator and configuration registers
module decode_stage #(
  parameter int ROB_DEPTH = 8,
  parameter int CNT_W     = 8
) (
  input  logic                    clk,
  input  logic                    rst_i,
  input  logic                    fetch_valid_i,
  input  decode_pkg::fetch_pkt_t  fetch_pkt_i,
  input  logic                    rename_stall_i,
  input  logic                    rob_flush_i,
  input  logic                    retire_i,
  input  logic                    cfg_we_i,
  input  logic [1:0]              cfg_addr_i,
  input  logic [31:0]             cfg_wdata_i,
  output logic [31:0]             cfg_rdata_o,
  output logic                    decode_stall_o,
  output logic                    rob_valid_o,
  output decode_pkg::rob_entry_t  rob_entry_o,
  output logic                    rename_valid_o,
  output decode_pkg::rename_uop_t rename_uop_o
);

  logic                            rob_full;
  logic [decode_pkg::ROB_ID_W-1:0] robid;
  logic                            alloc;
  logic                            illegal_seen;
  logic                            ext_lbcmp_en;
  logic                            ext_alu_en;

  insn_decoder i_insn_decoder (
    .clk            (clk),
    .rst_i          (rst_i),
    .fetch_valid_i  (fetch_valid_i),
    .fetch_pkt_i    (fetch_pkt_i),
    .rename_stall_i (rename_stall_i),
    .rob_flush_i    (rob_flush_i),
    .rob_full_i     (rob_full),
    .robid_i        (robid),
    .ext_lbcmp_en_i (ext_lbcmp_en),
    .ext_alu_en_i   (ext_alu_en),
    .decode_stall_o (decode_stall_o),
    .rob_valid_o    (rob_valid_o),
    .rob_entry_o    (rob_entry_o),
    .rename_valid_o (rename_valid_o),
    .rename_uop_o   (rename_uop_o),
    .alloc_o        (alloc),
    .illegal_o      (illegal_seen)
  );

  rob_id_allocator #(
    .ROB_DEPTH (ROB_DEPTH)
  ) i_rob_id_allocator (
    .clk        (clk),
    .rst_i      (rst_i),
    .alloc_i    (alloc),
    .retire_i   (retire_i),
    .flush_i    (rob_flush_i),
    .robid_o    (robid),
    .rob_full_o (rob_full)
  );

  decode_ctrl_regs #(
    .CNT_W (CNT_W)
  ) i_decode_ctrl_regs (
    .clk            (clk),
    .rst_i          (rst_i),
    .cfg_we_i       (cfg_we_i),
    .cfg_addr_i     (cfg_addr_i),
    .cfg_wdata_i    (cfg_wdata_i),
    .cfg_rdata_o    (cfg_rdata_o),
    .illegal_i      (illegal_seen),
    .ext_lbcmp_en_o (ext_lbcmp_en),
    .ext_alu_en_o   (ext_alu_en)
  );

endmodule

// ==== source/insn_decoder.sv ====
// decode register and combinational decode of one RV32I word into a rob entry and a rename uop
module insn_decoder (
  input  logic                            clk,
  input  logic                            rst_i,
  input  logic                            fetch_valid_i,
  input  decode_pkg::fetch_pkt_t          fetch_pkt_i,
  input  logic                            rename_stall_i,
  input  logic                            rob_flush_i,
  input  logic                            rob_full_i,
  input  logic [decode_pkg::ROB_ID_W-1:0] robid_i,
  input  logic                            ext_lbcmp_en_i,
  input  logic                            ext_alu_en_i,
  output logic                            decode_stall_o,
  output logic                            rob_valid_o,
  output decode_pkg::rob_entry_t          rob_entry_o,
  output logic                            rename_valid_o,
  output decode_pkg::rename_uop_t         rename_uop_o,
  output logic                            alloc_o,
  output logic                            illegal_o
);

  typedef struct packed {
    logic r;
    logic i;
    logic s;
    logic b;
    logic u;
    logic j;
  } fmt_t;

  logic                   valid_q;
  decode_pkg::fetch_pkt_t pkt_q;
  rv_isa_pkg::insn_u      insn;
  rv_isa_pkg::opc_e       opc;
  fmt_t                   fmt;
  logic                   fmt_inv;
  logic [31:0]            imm;
  logic [4:0]             rsop;
  logic [2:0]             funct3;
  logic [4:0]             rs1;
  logic                   insn_load;
  logic                   insn_jalr;
  logic                   insn_auipc;
  logic                   insn_csr;
  logic                   insn_lbcmp;
  logic                   insn_aluext;
  logic                   insn_complex;
  logic                   altop;
  logic [2:0]             brop;
  logic [2:0]             csrop;
  logic                   uses_rd;
  logic                   uses_memory;
  logic                   entry_err;
  logic [31:0]            target;

  always_ff @(posedge clk) begin
    if (rst_i | rob_flush_i) begin
      valid_q <= 1'b0;
    end else if (!decode_stall_o) begin
      valid_q <= fetch_valid_i;
    end
    if (!decode_stall_o && fetch_valid_i) begin
      pkt_q <= fetch_pkt_i;
    end
  end

  assign insn   = pkt_q.insn;
  assign opc    = rv_isa_pkg::opc_e'(insn.r.opcode[6:2]);
  assign funct3 = insn.r.funct3;
  assign rs1    = insn.r.rs1;

  // format decoder, custom groups only when enabled
  always_comb begin
    fmt = '0;
    fmt_inv = 1'b0;
    if (insn.r.opcode[1:0] != 2'b11) begin
      fmt_inv = 1'b1;
    end else begin
      case (opc)
        rv_isa_pkg::OPC_OP: fmt.r = 1'b1;
        rv_isa_pkg::OPC_OPIMM, rv_isa_pkg::OPC_LOAD, rv_isa_pkg::OPC_JALR,
        rv_isa_pkg::OPC_MISCMEM, rv_isa_pkg::OPC_SYSTEM: fmt.i = 1'b1;
        rv_isa_pkg::OPC_LUI, rv_isa_pkg::OPC_AUIPC: fmt.u = 1'b1;
        rv_isa_pkg::OPC_STORE: fmt.s = 1'b1;
        rv_isa_pkg::OPC_BRANCH: fmt.b = 1'b1;
        rv_isa_pkg::OPC_JAL: fmt.j = 1'b1;
        rv_isa_pkg::OPC_CUSTOM0: begin
          fmt.r = ext_lbcmp_en_i;
          fmt_inv = ~ext_lbcmp_en_i;
        end
        rv_isa_pkg::OPC_CUSTOM1: begin
          fmt.r = ext_alu_en_i;
          fmt_inv = ~ext_alu_en_i;
        end
        // fp, amo, rv64, other custom and reserved
        default: fmt_inv = 1'b1;
      endcase
    end
  end

  // sign-extended immediate
  always_comb begin
    case (1'b1)
      fmt.i: imm = {{20{insn.i.imm11_0[11]}}, insn.i.imm11_0};
      fmt.s: imm = {{20{insn.s.imm11_5[6]}}, insn.s.imm11_5, insn.s.imm4_0};
      fmt.b: imm = {{19{insn.b.imm12}}, insn.b.imm12, insn.b.imm11,
                    insn.b.imm10_5, insn.b.imm4_1, 1'b0};
      fmt.u: imm = {insn.u.imm31_12, 12'b0};
      fmt.j: imm = {{11{insn.j.imm20}}, insn.j.imm20, insn.j.imm19_12,
                    insn.j.imm11, insn.j.imm10_1, 1'b0};
      default: imm = '0;
    endcase
  end

  assign insn_load    = (opc == rv_isa_pkg::OPC_LOAD);
  assign insn_jalr    = (opc == rv_isa_pkg::OPC_JALR);
  assign insn_auipc   = (opc == rv_isa_pkg::OPC_AUIPC);
  assign insn_csr     = (opc == rv_isa_pkg::OPC_SYSTEM) & (funct3[1:0] != 2'b00);
  assign insn_lbcmp   = (opc == rv_isa_pkg::OPC_CUSTOM0) & (funct3[1:0] == 2'b11);
  assign insn_aluext  = (opc == rv_isa_pkg::OPC_CUSTOM1);
  assign insn_complex = fmt.r & insn.r.funct7[0];
  // srai/srli share funct3 101, bit 30 selects arithmetic
  assign altop        = (fmt.r | (funct3 == 3'b101)) & insn.r.funct7[5];
  assign brop         = {~|funct3[2:1], funct3[2:1]};
  assign csrop        = (funct3[1] & (rs1 == 5'd0)) ? 3'b000 : funct3;
  assign uses_rd      = (fmt.r | fmt.i | fmt.u | fmt.j) & (insn.r.rd != 5'd0);
  assign uses_memory  = insn_load | fmt.s | insn_lbcmp;

  always_comb begin
    if (uses_memory) begin
      rsop = {1'b0, fmt.s, funct3};
    end else if (fmt.j | insn_jalr | fmt.u) begin
      rsop = 5'b00000;
    end else if (fmt.b) begin
      rsop = {2'b01, brop};
    end else if (insn_csr) begin
      rsop = {2'b00, csrop};
    end else begin
      rsop = {insn_complex | insn_aluext, insn_complex | altop, funct3};
    end
  end

  // fall-through for jalr and predicted-taken branches
  assign target = {pkt_q.addr[31:2], 2'b00} +
                  (((fmt.b & pkt_q.bptaken) | insn_jalr) ? 32'd4 : imm);

  assign entry_err      = pkt_q.error | fmt_inv;
  assign decode_stall_o = rob_full_i | rename_stall_i;
  assign rob_valid_o    = valid_q & ~decode_stall_o;
  assign rename_valid_o = rob_valid_o & ~entry_err;
  assign alloc_o        = rob_valid_o;
  assign illegal_o      = rob_valid_o & ~pkt_q.error & fmt_inv;

  always_comb begin
    rob_entry_o.error   = entry_err;
    rob_entry_o.ecause  = pkt_q.error ?
                          (pkt_q.addr[1] ? rv_isa_pkg::ERR_IALIGN : rv_isa_pkg::ERR_IFAULT) :
                          rv_isa_pkg::ERR_IILLEGAL;
    rob_entry_o.retop   = {fmt.b, insn_csr, insn_jalr, fmt.s, funct3};
    rob_entry_o.rd      = {~uses_rd, insn.r.rd};
    rob_entry_o.addr    = pkt_q.addr[31:2];
    rob_entry_o.forward = insn_jalr;
    rob_entry_o.target  = target[31:2];
    rob_entry_o.bptag   = pkt_q.bptag;
    rob_entry_o.bptaken = pkt_q.bptaken;
  end

  always_comb begin
    rename_uop_o.rsop        = rsop;
    rename_uop_o.robid       = robid_i;
    rename_uop_o.uses_rs1    = fmt.r | (fmt.i & (~insn_csr | ~funct3[2])) | fmt.s | fmt.b;
    rename_uop_o.uses_rs2    = fmt.r | fmt.s | fmt.b;
    rename_uop_o.uses_imm    = ~fmt.r & ~fmt.b;
    rename_uop_o.uses_memory = uses_memory;
    rename_uop_o.uses_pc     = fmt.j | insn_auipc;
    rename_uop_o.csr_access  = insn_csr;
    rename_uop_o.inhibit     = insn_jalr;
    rename_uop_o.rs1         = rs1;
    rename_uop_o.rs2         = insn.r.rs2;
    rename_uop_o.rd          = {~uses_rd, insn.r.rd};
    // jal writes the link, rename adds 4 to the pc
    rename_uop_o.imm         = fmt.j ? 32'd4 : imm;
  end

  // fetch keeps its packet while decode stalls
  fetch_hold_a: assert property (
    @(posedge clk) disable iff (rst_i || rob_flush_i)
    (fetch_valid_i && decode_stall_o) |=> (fetch_valid_i && $stable(fetch_pkt_i)));

  // a held instruction keeps the id it will take
  held_robid_a: assert property (
    @(posedge clk) disable iff (rst_i || rob_flush_i)
    (valid_q && decode_stall_o) |=> $stable(robid_i));

endmodule

// ==== source/rob_id_allocator.sv ====
// hands out reorder-buffer ids in order and tracks how many entries are in flight
module rob_id_allocator #(
  parameter int ROB_DEPTH = 8
) (
  input  logic                            clk,
  input  logic                            rst_i,
  input  logic                            alloc_i,
  input  logic                            retire_i,
  input  logic                            flush_i,
  output logic [decode_pkg::ROB_ID_W-1:0] robid_o,
  output logic                            rob_full_o
);

  localparam int ID_W  = decode_pkg::ROB_ID_W;
  localparam int OCC_W = $clog2(ROB_DEPTH + 1);
  localparam logic [ID_W-1:0]  LAST_ID = ID_W'(ROB_DEPTH - 1);
  localparam logic [OCC_W-1:0] DEPTH   = OCC_W'(ROB_DEPTH);

  logic [ID_W-1:0]  id_q;
  logic [OCC_W-1:0] occ_q;

  // flush takes priority over alloc and retire
  always_ff @(posedge clk) begin
    if (rst_i | flush_i) begin
      id_q  <= '0;
      occ_q <= '0;
    end else begin
      if (alloc_i) begin
        id_q <= (id_q == LAST_ID) ? '0 : id_q + 1'b1;
      end
      case ({alloc_i, retire_i})
        2'b10:   occ_q <= occ_q + 1'b1;
        2'b01:   occ_q <= occ_q - 1'b1;
        default: occ_q <= occ_q;
      endcase
    end
  end

  assign robid_o    = id_q;
  assign rob_full_o = (occ_q == DEPTH);

  occ_bound_a: assert property (@(posedge clk) disable iff (rst_i) occ_q <= DEPTH);

  // rob only retires what decode allocated
  no_underflow_a: assert property (
    @(posedge clk) disable iff (rst_i || flush_i) retire_i |-> (occ_q != '0));

endmodule

// ==== source/rv_isa_pkg.sv ====
// RV32I instruction set definitions: major opcodes, exception causes and instruction formats
package rv_isa_pkg;

  // major opcode map, instruction bits 6:2
  typedef enum logic [4:0] {
    OPC_LOAD,      OPC_LOADFP,    OPC_CUSTOM0,   OPC_MISCMEM,
    OPC_OPIMM,     OPC_AUIPC,     OPC_OPIMM32,   OPC_48B0,
    OPC_STORE,     OPC_STOREFP,   OPC_CUSTOM1,   OPC_AMO,
    OPC_OP,        OPC_LUI,       OPC_OP32,      OPC_64B,
    OPC_MADD,      OPC_MSUB,      OPC_NMSUB,     OPC_NMADD,
    OPC_OPFP,      OPC_RESERVED0, OPC_CUSTOM2,   OPC_48B1,
    OPC_BRANCH,    OPC_JALR,      OPC_RESERVED1, OPC_JAL,
    OPC_SYSTEM,    OPC_RESERVED2, OPC_CUSTOM3,   OPC_80B
  } opc_e;

  // cause reported with an errored reorder-buffer entry
  typedef enum logic [1:0] {
    ERR_IALIGN   = 2'd0,
    ERR_IFAULT   = 2'd1,
    ERR_IILLEGAL = 2'd2
  } ecause_e;

  typedef struct packed {
    logic [6:0] funct7;
    logic [4:0] rs2;
    logic [4:0] rs1;
    logic [2:0] funct3;
    logic [4:0] rd;
    logic [6:0] opcode;
  } fmt_r_t;

  typedef struct packed {
    logic [11:0] imm11_0;
    logic [4:0]  rs1;
    logic [2:0]  funct3;
    logic [4:0]  rd;
    logic [6:0]  opcode;
  } fmt_i_t;

  typedef struct packed {
    logic [6:0] imm11_5;
    logic [4:0] rs2;
    logic [4:0] rs1;
    logic [2:0] funct3;
    logic [4:0] imm4_0;
    logic [6:0] opcode;
  } fmt_s_t;

  typedef struct packed {
    logic       imm12;
    logic [5:0] imm10_5;
    logic [4:0] rs2;
    logic [4:0] rs1;
    logic [2:0] funct3;
    logic [3:0] imm4_1;
    logic       imm11;
    logic [6:0] opcode;
  } fmt_b_t;

  typedef struct packed {
    logic [19:0] imm31_12;
    logic [4:0]  rd;
    logic [6:0]  opcode;
  } fmt_u_t;

  typedef struct packed {
    logic       imm20;
    logic [9:0] imm10_1;
    logic       imm11;
    logic [7:0] imm19_12;
    logic [4:0] rd;
    logic [6:0] opcode;
  } fmt_j_t;

  // one instruction word seen through each format
  typedef union packed {
    fmt_r_t r;
    fmt_i_t i;
    fmt_s_t s;
    fmt_b_t b;
    fmt_u_t u;
    fmt_j_t j;
  } insn_u;

endpackage

// ==== test/decode_ref.svh ====
// reference decode of one fetch packet, included by the decode stage testbench
`ifndef DECODE_REF_SVH
`define DECODE_REF_SVH

// robid is left at zero, the caller tracks it
function automatic void ref_decode(
  input  decode_pkg::fetch_pkt_t  p,
  input  logic                    lbcmp_en,
  input  logic                    alu_en,
  output decode_pkg::rob_entry_t  e,
  output decode_pkg::rename_uop_t u
);
  logic [31:0] w;
  logic [4:0]  op;
  logic [2:0]  f3;
  logic [31:0] imm;
  logic [31:0] tgt;
  logic        is_r;
  logic        is_i;
  logic        is_s;
  logic        is_b;
  logic        is_u;
  logic        is_j;
  logic        bad;
  logic        csr;
  logic        jalr;
  logic        mem;
  logic        cplx;
  logic        alt;
  logic        rd_none;
  w    = p.insn;
  op   = w[6:2];
  f3   = w[14:12];
  e    = '0;
  u    = '0;
  is_r = 1'b0;
  is_i = 1'b0;
  is_s = 1'b0;
  is_b = 1'b0;
  is_u = 1'b0;
  is_j = 1'b0;
  if (w[1:0] == 2'b11) begin
    case (op)
      rv_isa_pkg::OPC_OP:      is_r = 1'b1;
      rv_isa_pkg::OPC_CUSTOM0: is_r = lbcmp_en;
      rv_isa_pkg::OPC_CUSTOM1: is_r = alu_en;
      rv_isa_pkg::OPC_LOAD, rv_isa_pkg::OPC_MISCMEM, rv_isa_pkg::OPC_OPIMM,
      rv_isa_pkg::OPC_JALR, rv_isa_pkg::OPC_SYSTEM: is_i = 1'b1;
      rv_isa_pkg::OPC_LUI, rv_isa_pkg::OPC_AUIPC: is_u = 1'b1;
      rv_isa_pkg::OPC_STORE:   is_s = 1'b1;
      rv_isa_pkg::OPC_BRANCH:  is_b = 1'b1;
      rv_isa_pkg::OPC_JAL:     is_j = 1'b1;
      default: ;
    endcase
  end
  bad = !(is_r | is_i | is_s | is_b | is_u | is_j);

  // immediates straight from the instruction bits
  imm = 32'd0;
  if (is_i) imm = {{20{w[31]}}, w[31:20]};
  if (is_s) imm = {{20{w[31]}}, w[31:25], w[11:7]};
  if (is_b) imm = {{20{w[31]}}, w[7], w[30:25], w[11:8], 1'b0};
  if (is_u) imm = {w[31:12], 12'd0};
  if (is_j) imm = {{12{w[31]}}, w[19:12], w[20], w[30:21], 1'b0};

  csr     = (op == rv_isa_pkg::OPC_SYSTEM) && (f3[1:0] != 2'b00);
  jalr    = (op == rv_isa_pkg::OPC_JALR);
  mem     = (op == rv_isa_pkg::OPC_LOAD) || is_s ||
            ((op == rv_isa_pkg::OPC_CUSTOM0) && (f3[1:0] == 2'b11));
  cplx    = is_r && w[25];
  alt     = (is_r || f3 == 3'd5) && w[30];
  rd_none = !(is_r || is_i || is_u || is_j) || (w[11:7] == 5'd0);

  if (mem) u.rsop = {1'b0, is_s, f3};
  else if (is_j || jalr || is_u) u.rsop = 5'd0;
  else if (is_b) u.rsop = {2'b01, f3[2:1] == 2'b00, f3[2:1]};
  else if (csr) u.rsop = {2'b00, (f3[1] && w[19:15] == 5'd0) ? 3'd0 : f3};
  else u.rsop = {cplx || (op == rv_isa_pkg::OPC_CUSTOM1), cplx || alt, f3};

  tgt       = {p.addr[31:2], 2'b00} + ((jalr || (is_b && p.bptaken)) ? 32'd4 : imm);
  e.error   = p.error | bad;
  e.ecause  = p.error ? (p.addr[1] ? rv_isa_pkg::ERR_IALIGN : rv_isa_pkg::ERR_IFAULT) :
              rv_isa_pkg::ERR_IILLEGAL;
  e.retop   = {is_b, csr, jalr, is_s, f3};
  e.rd      = {rd_none, w[11:7]};
  e.addr    = p.addr[31:2];
  e.forward = jalr;
  e.target  = tgt[31:2];
  e.bptag   = p.bptag;
  e.bptaken = p.bptaken;

  u.uses_rs1    = is_r || (is_i && !(csr && f3[2])) || is_s || is_b;
  u.uses_rs2    = is_r || is_s || is_b;
  u.uses_imm    = !is_r && !is_b;
  u.uses_memory = mem;
  u.uses_pc     = is_j || (op == rv_isa_pkg::OPC_AUIPC);
  u.csr_access  = csr;
  u.inhibit     = jalr;
  u.rs1         = w[19:15];
  u.rs2         = w[24:20];
  u.rd          = e.rd;
  u.imm         = is_j ? 32'd4 : imm;
endfunction

`endif

// ==== test/decode_tb.sv ====
// testbench for the decode stage, random and directed instruction streams against a reference model
module decode_tb;

  `include "decode_ref.svh"

  localparam int ROB_DEPTH = 8;
  localparam int CNT_W     = 8;
  localparam int N_RAND    = 200;
  localparam int STIM_CYC  = N_RAND + 100;
  localparam int TIMEOUT   = (20 * STIM_CYC + 200) * 10;
  localparam logic [4:0] LEGAL_OPC [13] = '{5'd0, 5'd2, 5'd3, 5'd4, 5'd5, 5'd8, 5'd10,
                                            5'd12, 5'd13, 5'd24, 5'd25, 5'd27, 5'd28};

  logic                    clk;
  logic                    rst_i;
  logic                    fetch_valid_i;
  decode_pkg::fetch_pkt_t  fetch_pkt_i;
  logic                    rename_stall_i;
  logic                    rob_flush_i;
  logic                    retire_i = 1'b0;
  logic                    cfg_we_i;
  logic [1:0]              cfg_addr_i;
  logic [31:0]             cfg_wdata_i;
  logic [31:0]             cfg_rdata_o;
  logic                    decode_stall_o;
  logic                    rob_valid_o;
  decode_pkg::rob_entry_t  rob_entry_o;
  logic                    rename_valid_o;
  decode_pkg::rename_uop_t rename_uop_o;

  logic [31:0]             seed = 32'hb87b_6b8f;
  decode_pkg::fetch_pkt_t  pkt_q [$];
  int                      errors = 0;
  int                      checks = 0;
  int                      exp_id = 0;
  int                      occ = 0;
  int                      exp_illegal = 0;
  int                      cyc = 0;
  int                      retire_mode = 0;
  logic                    lb_en = 1'b1;
  logic                    alu_en = 1'b1;
  logic                    prev_acc = 1'b0;
  logic                    prev_stall = 1'b0;
  decode_pkg::rob_entry_t  prev_entry;
  decode_pkg::rename_uop_t prev_uop;

  decode_stage #(
    .ROB_DEPTH (ROB_DEPTH),
    .CNT_W     (CNT_W)
  ) i_decode_stage (
    .clk            (clk),
    .rst_i          (rst_i),
    .fetch_valid_i  (fetch_valid_i),
    .fetch_pkt_i    (fetch_pkt_i),
    .rename_stall_i (rename_stall_i),
    .rob_flush_i    (rob_flush_i),
    .retire_i       (retire_i),
    .cfg_we_i       (cfg_we_i),
    .cfg_addr_i     (cfg_addr_i),
    .cfg_wdata_i    (cfg_wdata_i),
    .cfg_rdata_o    (cfg_rdata_o),
    .decode_stall_o (decode_stall_o),
    .rob_valid_o    (rob_valid_o),
    .rob_entry_o    (rob_entry_o),
    .rename_valid_o (rename_valid_o),
    .rename_uop_o   (rename_uop_o)
  );

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  initial begin
    #(TIMEOUT);
    $display("timeout, stimulus did not finish within %0d time units", TIMEOUT);
    $display("CHECKS FAILED");
    $finish;
  end

  task automatic check(input string name, input logic [127:0] got, input logic [127:0] exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("Fail %0t %s got %0h expected %0h", $time, name, got, exp);
    end
  endtask

  function automatic logic [31:0] lcg_next();
    seed = seed * 32'd1664525 + 32'd1013904223;
    return seed;
  endfunction

  // mostly legal opcodes with random fields, some raw words
  function automatic logic [31:0] rand_word();
    logic [31:0] sel;
    logic [31:0] w;
    sel = lcg_next();
    w   = lcg_next();
    if (sel[31:29] == 3'b000) return w;
    return {w[31:7], LEGAL_OPC[sel[15:8] % 13], 2'b11};
  endfunction

  function automatic decode_pkg::fetch_pkt_t make_pkt(input logic [31:0] word, input logic err);
    decode_pkg::fetch_pkt_t p;
    logic [31:0] r;
    r         = lcg_next();
    p.error   = err;
    p.addr    = r[31:1];
    p.insn    = rv_isa_pkg::insn_u'(word);
    r         = lcg_next();
    p.bptag   = r[15:0];
    p.bptaken = r[16];
    return p;
  endfunction

  function automatic logic [6:0] flags_of(input decode_pkg::rename_uop_t u);
    return {u.uses_rs1, u.uses_rs2, u.uses_imm, u.uses_memory,
            u.uses_pc, u.csr_access, u.inhibit};
  endfunction

  // retire driver, 0 off, 1 three cycles in four, 2 every cycle
  always @(negedge clk) begin
    cyc++;
    retire_i = (occ > 0) && ((retire_mode == 2) || (retire_mode == 1 && cyc[1:0] != 2'b00));
  end

  // scoreboard, sampled on the rising edge before registers update
  always @(posedge clk) begin
    decode_pkg::fetch_pkt_t  p;
    decode_pkg::rob_entry_t  e;
    decode_pkg::rename_uop_t u;
    if (rst_i || rob_flush_i) begin
      pkt_q.delete();
      exp_id     = 0;
      occ        = 0;
      prev_acc   = 1'b0;
      prev_stall = 1'b0;
    end else begin
      check("decode_stall_o", decode_stall_o, (occ == ROB_DEPTH) || rename_stall_i);
      if (decode_stall_o) begin
        check("rob_valid_o", rob_valid_o, 1'b0);
        check("rename_valid_o", rename_valid_o, 1'b0);
      end else if (prev_acc) begin
        check("rob_valid_o", rob_valid_o, 1'b1);
      end
      // a held instruction keeps its outputs
      if (prev_stall && decode_stall_o && pkt_q.size() != 0) begin
        check("rob_entry_o", rob_entry_o, prev_entry);
        check("rename_uop_o", rename_uop_o, prev_uop);
      end
      if (rob_valid_o) begin
        if (pkt_q.size() == 0) begin
          errors++;
          $display("rob_valid_o pulsed at %0t with no instruction pending", $time);
        end else begin
          p = pkt_q.pop_front();
          ref_decode(p, lb_en, alu_en, e, u);
          check("rob_entry_o.error", rob_entry_o.error, e.error);
          check("rob_entry_o.ecause", rob_entry_o.ecause, e.ecause);
          check("rob_entry_o.addr", rob_entry_o.addr, e.addr);
          check("rob_entry_o.bptag", rob_entry_o.bptag, e.bptag);
          check("rob_entry_o.bptaken", rob_entry_o.bptaken, e.bptaken);
          check("rename_valid_o", rename_valid_o, !e.error);
          check("rename_uop_o.robid", rename_uop_o.robid, exp_id);
          if (!e.error) begin
            check("rob_entry_o.retop", rob_entry_o.retop, e.retop);
            check("rob_entry_o.rd", rob_entry_o.rd, e.rd);
            check("rob_entry_o.forward", rob_entry_o.forward, e.forward);
            check("rob_entry_o.target", rob_entry_o.target, e.target);
            check("rename_uop_o.rsop", rename_uop_o.rsop, u.rsop);
            check("rename_uop_o flags", flags_of(rename_uop_o), flags_of(u));
            check("rename_uop_o.rs1", rename_uop_o.rs1, u.rs1);
            check("rename_uop_o.rs2", rename_uop_o.rs2, u.rs2);
            check("rename_uop_o.rd", rename_uop_o.rd, u.rd);
            check("rename_uop_o.imm", rename_uop_o.imm, u.imm);
          end
          if (e.error && !p.error && exp_illegal < (1 << CNT_W) - 1) exp_illegal++;
        end
        exp_id = (exp_id + 1) % ROB_DEPTH;
        occ++;
      end
      if (retire_i) occ--;
      prev_acc = fetch_valid_i && !decode_stall_o;
      if (prev_acc) pkt_q.push_back(fetch_pkt_i);
      prev_stall = decode_stall_o;
      prev_entry = rob_entry_o;
      prev_uop   = rename_uop_o;
    end
  end

  // called on a falling edge, returns on the falling edge after acceptance
  task automatic send(input decode_pkg::fetch_pkt_t p);
    fetch_valid_i = 1'b1;
    fetch_pkt_i   = p;
    @(posedge clk);
    while (decode_stall_o) @(posedge clk);
    @(negedge clk);
    fetch_valid_i = 1'b0;
  endtask

  task automatic wait_drain();
    int n;
    n = 0;
    while (pkt_q.size() != 0 && n < 50) begin
      @(negedge clk);
      n++;
    end
    if (pkt_q.size() != 0) begin
      errors++;
      $display("instructions still pending in decode at %0t", $time);
    end
  endtask

  task automatic drain_rob();
    int n;
    n = 0;
    retire_mode = 2;
    while (occ != 0 && n < 50) begin
      @(negedge clk);
      n++;
    end
    retire_mode = 0;
    if (occ != 0) begin
      errors++;
      $display("reorder buffer did not empty at %0t", $time);
    end
  endtask

  task automatic read_cfg(input logic [1:0] addr, input logic [31:0] exp, input string name);
    cfg_addr_i = addr;
    @(posedge clk);
    check(name, cfg_rdata_o, exp);
    @(negedge clk);
  endtask

  initial begin
    decode_pkg::fetch_pkt_t p;
    rst_i          = 1'b1;
    fetch_valid_i  = 1'b0;
    fetch_pkt_i    = '0;
    rename_stall_i = 1'b0;
    rob_flush_i    = 1'b0;
    cfg_we_i       = 1'b0;
    cfg_addr_i     = 2'd0;
    cfg_wdata_i    = 32'd0;
    repeat (4) @(posedge clk);
    @(negedge clk);
    rst_i = 1'b0;
    check("rob_valid_o", rob_valid_o, 1'b0);
    check("rename_valid_o", rename_valid_o, 1'b0);
    read_cfg(2'd0, 32'd3, "cfg_rdata_o enables");
    read_cfg(2'd1, 32'd0, "cfg_rdata_o illegal count");

    // random stream with retires
    retire_mode = 1;
    repeat (N_RAND) send(make_pkt(rand_word(), 1'b0));
    wait_drain();
    drain_rob();

    // low bit pair, fp opcode, reserved opcode, fetch errors
    send(make_pkt(32'h0012_8a91, 1'b0));
    send(make_pkt(32'h0020_8053, 1'b0));
    send(make_pkt(32'h0000_0057, 1'b0));
    p = make_pkt(32'h0000_0013, 1'b1);
    p.addr[1] = 1'b1;
    send(p);
    p.addr[1] = 1'b0;
    send(p);
    wait_drain();
    drain_rob();

    // fill the rob, the ninth instruction waits in decode
    repeat (ROB_DEPTH + 1) send(make_pkt(rand_word(), 1'b0));
    repeat (5) @(negedge clk);
    check("held instructions", pkt_q.size(), 1);
    check("decode_stall_o when full", decode_stall_o, 1'b1);
    drain_rob();
    check("held instructions", pkt_q.size(), 0);

    // rename stall then release, then stall and flush
    send(make_pkt(rand_word(), 1'b0));
    rename_stall_i = 1'b1;
    repeat (4) @(negedge clk);
    rename_stall_i = 1'b0;
    wait_drain();
    send(make_pkt(rand_word(), 1'b0));
    rename_stall_i = 1'b1;
    @(negedge clk);
    rob_flush_i = 1'b1;
    @(negedge clk);
    rob_flush_i    = 1'b0;
    rename_stall_i = 1'b0;
    send(make_pkt(rand_word(), 1'b0));
    wait_drain();

    // custom groups disabled
    cfg_we_i    = 1'b1;
    cfg_addr_i  = 2'd0;
    cfg_wdata_i = 32'd0;
    @(negedge clk);
    cfg_we_i = 1'b0;
    lb_en    = 1'b0;
    alu_en   = 1'b0;
    read_cfg(2'd0, 32'd0, "cfg_rdata_o enables");
    send(make_pkt(32'h0020_b00b, 1'b0));
    send(make_pkt(32'h0020_802b, 1'b0));
    wait_drain();
    read_cfg(2'd1, exp_illegal, "cfg_rdata_o illegal count");

    $display("%0d checks, %0d errors", checks, errors);
    if (errors == 0) begin
      $display("ALL CHECKS PASSED");
    end else begin
      $display("CHECKS FAILED");
    end
    $finish;
  end

endmodule
